/* Makefile */
TOP = tb_branchUnit

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f branchUnit.f

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

/* branchExecute.sv */
`timescale 1ns/1ps
`default_nettype none

module branchExecute (
  input  logic  clk,
  input  logic  rst,
  decodeBus.exe dec,
  execBus.exe   exe
);

  localparam int W = branchPkg::XLEN;
  // link step for 16 and 32 bit encodings
  localparam logic [W-1:0] stepNarrow = 2;
  localparam logic [W-1:0] stepWide   = 4;

  logic         eq;
  logic         ltSigned;
  logic         ltUnsigned;
  logic         taken;
  logic [W-1:0] sum;
  logic [W-1:0] target;
  logic [W-1:0] link;

  // condition evaluation
  always_comb begin
    eq         = dec.rs1Val == dec.rs2Val;
    ltSigned   = $signed(dec.rs1Val) < $signed(dec.rs2Val);
    ltUnsigned = dec.rs1Val < dec.rs2Val;
    case (dec.op)
      branchPkg::opBeq:  taken = eq;
      branchPkg::opBne:  taken = !eq;
      branchPkg::opBlt:  taken = ltSigned;
      branchPkg::opBge:  taken = !ltSigned;
      branchPkg::opBltu: taken = ltUnsigned;
      branchPkg::opBgeu: taken = !ltUnsigned;
      // jumps always go
      branchPkg::opJal,
      branchPkg::opJalr: taken = 1'b1;
      default:           taken = 1'b0;
    endcase
  end

  // pc relative or register based target
  assign sum = (dec.useRs1Base ? dec.rs1Val : dec.pc) + dec.imm;

  always_comb begin
    if (dec.op == branchPkg::opNone) begin
      target = '0;
    end else if (dec.useRs1Base) begin
      // jalr clears bit 0
      target = {sum[W-1:1], 1'b0};
    end else begin
      target = sum;
    end
  end

  assign link = dec.pc + (dec.compressed ? stepNarrow : stepWide);

  always_ff @(posedge clk) begin
    if (rst) begin
      exe.valid <= 1'b0;
    end else begin
      exe.valid <= dec.valid;
    end
  end

  // result payload
  always_ff @(posedge clk) begin
    if (dec.valid) begin
      exe.op            <= dec.op;
      exe.taken         <= taken;
      exe.target        <= target;
      exe.link          <= link;
      exe.compressed    <= dec.compressed;
      exe.pushCallStack <= dec.pushCallStack;
      exe.popCallStack  <= dec.popCallStack;
    end
  end

endmodule

`default_nettype wire

/* branchPkg.sv */
`default_nettype none

package branchPkg;

  // data path width, RV32 only
  localparam int XLEN = 32;

  // resolved jump operation
  // conditional codes keep the old jumpType numbering
  // unconditional jumps live in the upper half
  typedef enum logic [4:0] {
    opBeq  = 5'd0,
    opBne  = 5'd1,
    opBlt  = 5'd11,
    opBge  = 5'd10,
    opBltu = 5'd7,
    opBgeu = 5'd6,
    opJal  = 5'd16,
    opJalr = 5'd17,
    // anything that is not a branch or jump
    opNone = 5'd31
  } jumpOp;

  // wishbone word addresses
  // pc, rs1, rs2 and instr are write only
  localparam logic [2:0] regPc      = 3'd0;
  localparam logic [2:0] regRs1     = 3'd1;
  localparam logic [2:0] regRs2     = 3'd2;
  // writing here launches the instruction
  localparam logic [2:0] regInstr   = 3'd3;
  // head entry of the result queue, read only
  localparam logic [2:0] regTarget  = 3'd4;
  localparam logic [2:0] regLink    = 3'd5;
  // read pops the head entry
  localparam logic [2:0] regFlags   = 3'd6;
  localparam logic [2:0] regPredRet = 3'd7;

  // bit positions in the flags word
  localparam int flagValid      = 0;
  localparam int flagTaken      = 1;
  localparam int flagIsJump     = 2;
  // return stack hints as decoded
  localparam int flagPush       = 3;
  localparam int flagPop        = 4;
  // 16-bit encoding
  localparam int flagCompressed = 5;
  // jumpOp field
  localparam int flagOpLo       = 8;
  localparam int flagOpHi       = 12;

endpackage

`default_nettype wire

/* branchResult.sv */
`timescale 1ns/1ps
`default_nettype none

module branchResult #(
  parameter int RAS_DEPTH   = 8,
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                       clk,
  input  logic                       rst,
  execBus.res                        exe,
  input  logic                       issue,
  input  logic                       pop,
  output logic                       issueReady,
  output logic                       headValid,
  output logic [branchPkg::XLEN-1:0] headTarget,
  output logic [branchPkg::XLEN-1:0] headLink,
  output logic [branchPkg::XLEN-1:0] headFlags,
  output logic [branchPkg::XLEN-1:0] headPredRet
);

  localparam int W       = branchPkg::XLEN;
  localparam int rasBits = $clog2(RAS_DEPTH);
  localparam int ptrBits = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int cntBits = $clog2(QUEUE_DEPTH + 1);

  // queue pointer wrap, depth need not be a power of two
  function automatic logic [ptrBits-1:0] nextPtr(input logic [ptrBits-1:0] p);
    return (p == ptrBits'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  logic [W-1:0]       ras [RAS_DEPTH];
  logic [rasBits-1:0] rasPtr;
  logic [rasBits-1:0] popPtr;
  logic [W-1:0]       predRet;
  logic [W-1:0]       flags;

  logic [W-1:0]       qTarget  [QUEUE_DEPTH];
  logic [W-1:0]       qLink    [QUEUE_DEPTH];
  logic [W-1:0]       qFlags   [QUEUE_DEPTH];
  logic [W-1:0]       qPredRet [QUEUE_DEPTH];
  logic [ptrBits-1:0] headPtr;
  logic [ptrBits-1:0] tailPtr;
  logic [cntBits-1:0] count;
  // queued plus in flight
  logic [cntBits-1:0] credits;
  logic               popHead;

  // pop reads below the pointer, push then writes where the pop left it
  assign popPtr  = exe.popCallStack ? rasPtr - 1'b1 : rasPtr;
  assign predRet = exe.popCallStack ? ras[popPtr] : '0;

  // circular stack, oldest entry is overwritten on wrap
  always_ff @(posedge clk) begin
    if (rst) begin
      rasPtr <= '0;
      for (int i = 0; i < RAS_DEPTH; i++) begin
        ras[i] <= '0;
      end
    end else if (exe.valid) begin
      if (exe.pushCallStack) begin
        ras[popPtr] <= exe.link;
        rasPtr      <= popPtr + 1'b1;
      end else begin
        rasPtr <= popPtr;
      end
    end
  end

  // flags word for the host
  always_comb begin
    flags = '0;
    flags[branchPkg::flagValid]      = 1'b1;
    flags[branchPkg::flagTaken]      = exe.taken;
    flags[branchPkg::flagIsJump]     = exe.op != branchPkg::opNone;
    flags[branchPkg::flagPush]       = exe.pushCallStack;
    flags[branchPkg::flagPop]        = exe.popCallStack;
    flags[branchPkg::flagCompressed] = exe.compressed;
    flags[branchPkg::flagOpHi:branchPkg::flagOpLo] = exe.op;
  end

  // queue storage
  always_ff @(posedge clk) begin
    if (exe.valid) begin
      qTarget[tailPtr]  <= exe.target;
      qLink[tailPtr]    <= exe.link;
      qFlags[tailPtr]   <= flags;
      qPredRet[tailPtr] <= predRet;
    end
  end

  assign headValid = count != '0;
  // host pop on an empty queue is ignored
  assign popHead   = pop && headValid;

  always_ff @(posedge clk) begin
    if (rst) begin
      headPtr <= '0;
      tailPtr <= '0;
      count   <= '0;
    end else begin
      if (exe.valid) begin
        tailPtr <= nextPtr(tailPtr);
      end
      if (popHead) begin
        headPtr <= nextPtr(headPtr);
      end
      case ({exe.valid, popHead})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  // credit taken at issue, returned at pop
  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= '0;
    end else begin
      case ({issue, popHead})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: ;
      endcase
    end
  end

  assign issueReady  = credits < cntBits'(QUEUE_DEPTH);

  // raw head entry, top level masks it when empty
  assign headTarget  = qTarget[headPtr];
  assign headLink    = qLink[headPtr];
  assign headFlags   = qFlags[headPtr];
  assign headPredRet = qPredRet[headPtr];

endmodule

`default_nettype wire

/* branchUnit.f */
branchPkg.sv
decodeBus.sv
execBus.sv
jumpDecoder.sv
branchExecute.sv
branchResult.sv
branchUnit.sv
branchUnit_chk.sv
tb_branchUnit.sv

/* branchUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module branchUnit #(
  parameter int RAS_DEPTH   = 8,
  parameter int QUEUE_DEPTH = 4
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        wbCyc,
  input  logic        wbStb,
  input  logic        wbWe,
  input  logic [2:0]  wbAdr,
  input  logic [31:0] wbDatIn,
  output logic [31:0] wbDatOut,
  output logic        wbAck
);

  localparam int W = branchPkg::XLEN;

  // host operand registers
  logic [W-1:0] pcReg;
  logic [W-1:0] rs1Reg;
  logic [W-1:0] rs2Reg;

  logic         request;
  logic         instrWrite;
  logic         ackCycle;
  logic         issue;
  logic         pop;
  logic         issueReady;
  logic         headValid;
  logic [W-1:0] headTarget;
  logic [W-1:0] headLink;
  logic [W-1:0] headFlags;
  logic [W-1:0] headPredRet;

  decodeBus decIf ();
  execBus   exeIf ();

  // new request, not the one being acked
  assign request    = wbCyc && wbStb && !wbAck;
  assign instrWrite = wbWe && (wbAdr == branchPkg::regInstr);

  // registered ack, instr writes wait for a free credit
  always_ff @(posedge clk) begin
    if (rst) begin
      wbAck <= 1'b0;
    end else begin
      wbAck <= request && (!instrWrite || issueReady);
    end
  end

  // side effects happen in the ack cycle
  assign ackCycle = wbAck && wbCyc && wbStb;
  assign issue    = ackCycle && instrWrite;
  assign pop      = ackCycle && !wbWe && (wbAdr == branchPkg::regFlags);

  always_ff @(posedge clk) begin
    if (ackCycle && wbWe) begin
      case (wbAdr)
        branchPkg::regPc:  pcReg  <= wbDatIn;
        branchPkg::regRs1: rs1Reg <= wbDatIn;
        branchPkg::regRs2: rs2Reg <= wbDatIn;
        default: ;
      endcase
    end
  end

  // read mux, head entry or zero
  always_comb begin
    wbDatOut = '0;
    if (headValid) begin
      case (wbAdr)
        branchPkg::regTarget:  wbDatOut = headTarget;
        branchPkg::regLink:    wbDatOut = headLink;
        branchPkg::regFlags:   wbDatOut = headFlags;
        branchPkg::regPredRet: wbDatOut = headPredRet;
        // write only registers read as zero
        default:               wbDatOut = '0;
      endcase
    end
  end

  jumpDecoder decoder (
    .clk    (clk),
    .rst    (rst),
    .issue  (issue),
    .instr  (wbDatIn),
    .pc     (pcReg),
    .rs1Val (rs1Reg),
    .rs2Val (rs2Reg),
    .dec    (decIf)
  );

  branchExecute execute (
    .clk (clk),
    .rst (rst),
    .dec (decIf),
    .exe (exeIf)
  );

  branchResult #(
    .RAS_DEPTH   (RAS_DEPTH),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) result (
    .clk         (clk),
    .rst         (rst),
    .exe         (exeIf),
    .issue       (issue),
    .pop         (pop),
    .issueReady  (issueReady),
    .headValid   (headValid),
    .headTarget  (headTarget),
    .headLink    (headLink),
    .headFlags   (headFlags),
    .headPredRet (headPredRet)
  );

endmodule

`default_nettype wire

/* branchUnit_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module branchUnit_chk #(
  parameter int QUEUE_DEPTH = 4
) (
  input logic                               clk,
  input logic                               rst,
  input logic                               wbCyc,
  input logic                               wbStb,
  input logic                               wbAck,
  input logic [$clog2(QUEUE_DEPTH + 1)-1:0] credits
);

  localparam int cntBits = $clog2(QUEUE_DEPTH + 1);

  // ack is a single cycle pulse
  ackPulse: assert property (@(posedge clk) disable iff (rst) wbAck |=> !wbAck)
    else $error("wbAck high on two consecutive cycles");

  // no ack outside a strobed cycle
  ackQualified: assert property (@(posedge clk) disable iff (rst) wbAck |-> (wbCyc && wbStb))
    else $error("wbAck without wbCyc and wbStb");

  // queued plus in flight stays within the queue
  creditBound: assert property (@(posedge clk) disable iff (rst)
                                credits <= cntBits'(QUEUE_DEPTH))
    else $error("credit count above queue depth");

endmodule

`default_nettype wire

/* decodeBus.sv */
`timescale 1ns/1ps
`default_nettype none

// decoded instruction handed from decode to execute
// valid is a one cycle qualifier, no handshake
interface decodeBus;
  logic                       valid;
  branchPkg::jumpOp           op;
  logic [branchPkg::XLEN-1:0] imm;
  logic [branchPkg::XLEN-1:0] pc;
  logic [branchPkg::XLEN-1:0] rs1Val;
  // already zero for the compare-with-zero forms
  logic [branchPkg::XLEN-1:0] rs2Val;
  logic                       compressed;
  // target base is rs1 instead of pc
  logic                       useRs1Base;
  logic                       pushCallStack;
  logic                       popCallStack;

  modport dec (output valid, op, imm, pc, rs1Val, rs2Val, compressed,
               useRs1Base, pushCallStack, popCallStack);
  modport exe (input valid, op, imm, pc, rs1Val, rs2Val, compressed,
               useRs1Base, pushCallStack, popCallStack);
endinterface

`default_nettype wire

/* execBus.sv */
`timescale 1ns/1ps
`default_nettype none

// resolved branch handed from execute to result
// valid is a one cycle qualifier, no handshake
interface execBus;
  logic                       valid;
  branchPkg::jumpOp           op;
  logic                       taken;
  // zero for non-jumps
  logic [branchPkg::XLEN-1:0] target;
  // return address, pc+2 or pc+4
  logic [branchPkg::XLEN-1:0] link;
  logic                       compressed;
  logic                       pushCallStack;
  logic                       popCallStack;

  modport exe (output valid, op, taken, target, link, compressed,
               pushCallStack, popCallStack);
  modport res (input valid, op, taken, target, link, compressed,
               pushCallStack, popCallStack);
endinterface

`default_nettype wire

/* jumpDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module jumpDecoder (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       issue,
  input  logic [31:0]                instr,
  input  logic [branchPkg::XLEN-1:0] pc,
  input  logic [branchPkg::XLEN-1:0] rs1Val,
  input  logic [branchPkg::XLEN-1:0] rs2Val,
  decodeBus.dec                      dec
);

  // x1 and x5 serve as link registers
  function automatic logic isLink(input logic [4:0] r);
    return (r == 5'd1) || (r == 5'd5);
  endfunction

  logic             isWide;
  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [4:0]       rd;
  logic [4:0]       rs1;
  logic [2:0]       cFunct3;
  logic [4:0]       cRs1;
  logic [4:0]       cRs2;

  branchPkg::jumpOp nextOp;
  logic [31:0]      nextImm;
  logic             nextUseRs1;
  logic             nextPush;
  logic             nextPop;
  logic             zeroRs2;

  // low bits 11 mean a full 32-bit encoding
  assign isWide  = instr[1:0] == 2'b11;
  assign opcode  = instr[6:0];
  assign funct3  = instr[14:12];
  assign rd      = instr[11:7];
  assign rs1     = instr[19:15];
  // compressed fields
  assign cFunct3 = instr[15:13];
  assign cRs1    = instr[11:7];
  assign cRs2    = instr[6:2];

  always_comb begin
    nextOp     = branchPkg::opNone;
    nextImm    = '0;
    nextUseRs1 = 1'b0;
    nextPush   = 1'b0;
    nextPop    = 1'b0;
    zeroRs2    = 1'b0;
    if (isWide) begin
      case (opcode)
        // conditional branch, B-type immediate
        7'b1100011: begin
          nextImm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
          case (funct3)
            3'b000:  nextOp = branchPkg::opBeq;
            3'b001:  nextOp = branchPkg::opBne;
            3'b100:  nextOp = branchPkg::opBlt;
            3'b101:  nextOp = branchPkg::opBge;
            3'b110:  nextOp = branchPkg::opBltu;
            3'b111:  nextOp = branchPkg::opBgeu;
            // 010 and 011 are reserved
            default: nextImm = '0;
          endcase
        end
        // jal, J-type immediate
        7'b1101111: begin
          nextOp   = branchPkg::opJal;
          nextImm  = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
          nextPush = isLink(rd);
        end
        // jalr, only funct3 000 is legal
        7'b1100111: begin
          if (funct3 == 3'b000) begin
            nextOp     = branchPkg::opJalr;
            nextImm    = {{20{instr[31]}}, instr[31:20]};
            nextUseRs1 = 1'b1;
            nextPush   = isLink(rd);
            // return only when rd is not a link
            nextPop    = isLink(rs1) && !isLink(rd);
          end
        end
        // alu, load, store, system etc
        default: ;
      endcase
    end else if (instr[1:0] == 2'b01) begin
      case (cFunct3)
        // c.j and c.jal share the CJ scatter
        3'b101, 3'b001: begin
          nextOp   = branchPkg::opJal;
          nextImm  = {{20{instr[12]}}, instr[12], instr[8], instr[10:9], instr[6],
                      instr[7], instr[2], instr[11], instr[5:3], 1'b0};
          // c.jal writes x1
          nextPush = !cFunct3[2];
        end
        // c.beqz and c.bnez compare against zero
        3'b110, 3'b111: begin
          nextOp  = cFunct3[0] ? branchPkg::opBne : branchPkg::opBeq;
          nextImm = {{23{instr[12]}}, instr[12], instr[6:5], instr[2], instr[11:10],
                     instr[4:3], 1'b0};
          zeroRs2 = 1'b1;
        end
        default: ;
      endcase
    end else if (instr[1:0] == 2'b10) begin
      // c.jr and c.jalr, funct4 100x with rs2 zero and rs1 nonzero
      if (cFunct3 == 3'b100 && cRs2 == 5'd0 && cRs1 != 5'd0) begin
        nextOp     = branchPkg::opJalr;
        nextUseRs1 = 1'b1;
        if (instr[12]) begin
          // c.jalr links through x1
          nextPush = 1'b1;
        end else begin
          nextPop = isLink(cRs1);
        end
      end
    end
  end

  // stage valid
  always_ff @(posedge clk) begin
    if (rst) begin
      dec.valid <= 1'b0;
    end else begin
      dec.valid <= issue;
    end
  end

  // stage payload, loaded on issue only
  always_ff @(posedge clk) begin
    if (issue) begin
      dec.op            <= nextOp;
      dec.imm           <= nextImm;
      dec.pc            <= pc;
      dec.rs1Val        <= rs1Val;
      dec.rs2Val        <= zeroRs2 ? '0 : rs2Val;
      dec.compressed    <= !isWide;
      dec.useRs1Base    <= nextUseRs1;
      dec.pushCallStack <= nextPush;
      dec.popCallStack  <= nextPop;
    end
  end

endmodule

`default_nettype wire

/* tb_branchUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_branchUnit;

  localparam int RAS_DEPTH   = 8;
  localparam int QUEUE_DEPTH = 4;

  // instruction classes for the stimulus
  localparam int kindBranch  = 0;
  localparam int kindJal     = 1;
  localparam int kindJalr    = 2;
  localparam int kindCj      = 3;
  localparam int kindCjal    = 4;
  localparam int kindCjr     = 5;
  localparam int kindCjalr   = 6;
  localparam int kindCbranch = 7;
  localparam int kindOther   = 8;

  logic        clk;
  logic        rst;
  logic        wbCyc;
  logic        wbStb;
  logic        wbWe;
  logic [2:0]  wbAdr;
  logic [31:0] wbDatIn;
  logic [31:0] wbDatOut;
  logic        wbAck;

  logic [15:0] lfsrState;
  int          checkCount;
  int          errorCount;

  // instruction being built and its expected result
  logic [31:0]      curPc;
  logic [31:0]      curRs1;
  logic [31:0]      curRs2;
  logic [31:0]      curInstr;
  branchPkg::jumpOp expOp;
  logic             expTaken;
  logic             expPush;
  logic             expPop;
  logic             expComp;
  logic [31:0]      expTarget;
  logic [31:0]      expLink;

  // reference return stack
  logic [31:0] rasModel [RAS_DEPTH];
  int          rasPtrModel;

  // expected queue contents in issue order
  logic [31:0] qTarget [$];
  logic [31:0] qLink [$];
  logic [31:0] qFlags [$];
  logic [31:0] qPredRet [$];

  branchUnit #(
    .RAS_DEPTH   (RAS_DEPTH),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) uut (
    .clk      (clk),
    .rst      (rst),
    .wbCyc    (wbCyc),
    .wbStb    (wbStb),
    .wbWe     (wbWe),
    .wbAdr    (wbAdr),
    .wbDatIn  (wbDatIn),
    .wbDatOut (wbDatOut),
    .wbAck    (wbAck)
  );

  bind branchUnit branchUnit_chk #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) chk (
    .clk     (clk),
    .rst     (rst),
    .wbCyc   (wbCyc),
    .wbStb   (wbStb),
    .wbAck   (wbAck),
    .credits (result.credits)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // galois lfsr stepped once per bit
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    logic        lsb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lsb       = lfsrState[0];
      v         = {v[30:0], lsb};
      lfsrState = lfsrState >> 1;
      if (lsb) begin
        lfsrState = lfsrState ^ 16'hB400;
      end
    end
    return v;
  endfunction

  // operand with signed and unsigned corner cases
  function automatic logic [31:0] pickValue();
    logic [31:0] sel;
    sel = randBits(3);
    case (sel)
      32'd0:   return 32'h0000_0000;
      32'd1:   return 32'h0000_0001;
      32'd2:   return 32'h7FFF_FFFF;
      32'd3:   return 32'h8000_0000;
      32'd4:   return 32'hFFFF_FFFF;
      default: return randBits(32);
    endcase
  endfunction

  // register number biased toward x0, x1, x5
  function automatic logic [4:0] pickReg();
    logic [31:0] sel;
    logic [31:0] r;
    sel = randBits(2);
    r   = randBits(5);
    case (sel)
      32'd0:   return 5'd1;
      32'd1:   return 5'd5;
      32'd2:   return 5'd0;
      default: return r[4:0];
    endcase
  endfunction

  function automatic logic isLinkReg(input logic [4:0] r);
    return (r == 5'd1) || (r == 5'd5);
  endfunction

  task automatic checkEq(input string what, input logic [31:0] got, input logic [31:0] exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("FAIL %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // one classic cycle entered on a falling edge
  task automatic busCycle(input logic we, input logic [2:0] adr, input logic [31:0] wdata,
                          input int limit, output logic [31:0] rdata, output logic acked);
    int n;
    n       = 0;
    acked   = 1'b0;
    rdata   = '0;
    wbCyc   = 1'b1;
    wbStb   = 1'b1;
    wbWe    = we;
    wbAdr   = adr;
    wbDatIn = wdata;
    while (!acked && n < limit) begin
      @(negedge clk);
      n++;
      if (wbAck) begin
        acked = 1'b1;
        rdata = wbDatOut;
      end
    end
    // keep the strobe through the acking edge
    if (acked) begin
      @(negedge clk);
    end
    wbCyc   = 1'b0;
    wbStb   = 1'b0;
    wbWe    = 1'b0;
    wbDatIn = '0;
  endtask

  task automatic writeReg(input logic [2:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    logic        acked;
    busCycle(1'b1, adr, data, 20, unused, acked);
    if (!acked) begin
      errorCount++;
      $display("timeout: write to register %0d was never acknowledged", adr);
    end
  endtask

  task automatic readReg(input logic [2:0] adr, output logic [31:0] data);
    logic acked;
    busCycle(1'b0, adr, '0, 20, data, acked);
    if (!acked) begin
      errorCount++;
      $display("timeout: read of register %0d was never acknowledged", adr);
    end
  endtask

  // encode one instruction of the given class and work out the result
  task automatic makeInstr(input int kind);
    logic [31:0] r;
    logic [31:0] imm;
    logic [31:0] cmpB;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic        useBase;
    r      = randBits(32);
    curPc  = {r[31:1], 1'b0};
    curRs1 = pickValue();
    r      = randBits(2);
    curRs2 = (r[1:0] == 2'd0) ? curRs1 : pickValue();
    rd     = pickReg();
    rs1    = pickReg();
    r      = randBits(5);
    rs2    = r[4:0];
    cmpB    = curRs2;
    imm     = '0;
    useBase = 1'b0;
    expOp   = branchPkg::opNone;
    expPush = 1'b0;
    expPop  = 1'b0;
    expComp = 1'b0;
    case (kind)
      kindBranch: begin
        r   = randBits(12);
        imm = {{19{r[11]}}, r[11:0], 1'b0};
        r   = randBits(3);
        f3  = r[2:0];
        // reserved 010 and 011 fold onto the unsigned pair
        if (f3 == 3'b010 || f3 == 3'b011) begin
          f3 = f3 + 3'd4;
        end
        case (f3)
          3'b000:  expOp = branchPkg::opBeq;
          3'b001:  expOp = branchPkg::opBne;
          3'b100:  expOp = branchPkg::opBlt;
          3'b101:  expOp = branchPkg::opBge;
          3'b110:  expOp = branchPkg::opBltu;
          default: expOp = branchPkg::opBgeu;
        endcase
        curInstr = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
      end
      kindJal: begin
        r        = randBits(20);
        imm      = {{11{r[19]}}, r[19:0], 1'b0};
        expOp    = branchPkg::opJal;
        expPush  = isLinkReg(rd);
        curInstr = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
      end
      kindJalr: begin
        r        = randBits(12);
        imm      = {{20{r[11]}}, r[11:0]};
        expOp    = branchPkg::opJalr;
        useBase  = 1'b1;
        expPush  = isLinkReg(rd);
        expPop   = isLinkReg(rs1) && !isLinkReg(rd);
        curInstr = {imm[11:0], rs1, 3'b000, rd, 7'b1100111};
      end
      kindCj, kindCjal: begin
        r        = randBits(11);
        imm      = {{20{r[10]}}, r[10:0], 1'b0};
        expOp    = branchPkg::opJal;
        expComp  = 1'b1;
        // c.jal writes x1
        expPush  = (kind == kindCjal);
        f3       = expPush ? 3'b001 : 3'b101;
        curInstr = {16'h0, f3, imm[11], imm[4], imm[9:8], imm[10], imm[6], imm[7],
                    imm[3:1], imm[5], 2'b01};
      end
      kindCjr, kindCjalr: begin
        if (rs1 == 5'd0) begin
          rs1 = 5'd1;
        end
        expOp    = branchPkg::opJalr;
        expComp  = 1'b1;
        useBase  = 1'b1;
        expPush  = (kind == kindCjalr);
        expPop   = !expPush && isLinkReg(rs1);
        curInstr = {16'h0, 3'b100, expPush, rs1, 5'd0, 2'b10};
      end
      kindCbranch: begin
        r        = randBits(8);
        imm      = {{23{r[7]}}, r[7:0], 1'b0};
        r        = randBits(1);
        expOp    = r[0] ? branchPkg::opBne : branchPkg::opBeq;
        expComp  = 1'b1;
        // c.beqz and c.bnez test rs1 against zero
        cmpB     = '0;
        curInstr = {16'h0, 2'b11, r[0], imm[8], imm[4:3], rs2[2:0], imm[7:6], imm[2:1],
                    imm[5], 2'b01};
      end
      default: begin
        r = randBits(1);
        if (r[0]) begin
          // quadrant 00 is never a jump
          r        = randBits(14);
          expComp  = 1'b1;
          curInstr = {16'h0, r[13:0], 2'b00};
        end else begin
          r  = randBits(3);
          f3 = r[2:0];
          r  = randBits(25);
          case (f3)
            3'd1:    curInstr = {r[24:0], 7'b0110011};
            3'd2:    curInstr = {r[24:0], 7'b0000011};
            3'd3:    curInstr = {r[24:0], 7'b0100011};
            3'd4:    curInstr = {r[24:0], 7'b1110011};
            3'd5:    curInstr = {r[24:0], 7'b0110111};
            3'd6:    curInstr = {r[24:0], 7'b0010111};
            default: curInstr = {r[24:0], 7'b0010011};
          endcase
        end
      end
    endcase

    case (expOp)
      branchPkg::opBeq:  expTaken = curRs1 == cmpB;
      branchPkg::opBne:  expTaken = curRs1 != cmpB;
      branchPkg::opBlt:  expTaken = $signed(curRs1) < $signed(cmpB);
      branchPkg::opBge:  expTaken = $signed(curRs1) >= $signed(cmpB);
      branchPkg::opBltu: expTaken = curRs1 < cmpB;
      branchPkg::opBgeu: expTaken = curRs1 >= cmpB;
      branchPkg::opJal,
      branchPkg::opJalr: expTaken = 1'b1;
      default:           expTaken = 1'b0;
    endcase

    if (expOp == branchPkg::opNone) begin
      expTarget = '0;
    end else if (useBase) begin
      expTarget = (curRs1 + imm) & 32'hFFFF_FFFE;
    end else begin
      expTarget = curPc + imm;
    end
    expLink = curPc + (expComp ? 32'd2 : 32'd4);
  endtask

  // accepted instruction updates the stack model and the expected queue
  task automatic acceptModel();
    logic [31:0] predRet;
    logic [31:0] flags;
    predRet = '0;
    if (expPop) begin
      rasPtrModel = (rasPtrModel + RAS_DEPTH - 1) % RAS_DEPTH;
      predRet     = rasModel[rasPtrModel];
    end
    if (expPush) begin
      rasModel[rasPtrModel] = expLink;
      rasPtrModel           = (rasPtrModel + 1) % RAS_DEPTH;
    end
    flags        = 32'h1;
    flags[1]     = expTaken;
    flags[2]     = expOp != branchPkg::opNone;
    flags[3]     = expPush;
    flags[4]     = expPop;
    flags[5]     = expComp;
    flags[12:8]  = expOp;
    qTarget.push_back(expTarget);
    qLink.push_back(expLink);
    qFlags.push_back(flags);
    qPredRet.push_back(predRet);
  endtask

  task automatic sendInstr(input int limit, output logic acked);
    logic [31:0] unused;
    writeReg(branchPkg::regPc, curPc);
    writeReg(branchPkg::regRs1, curRs1);
    writeReg(branchPkg::regRs2, curRs2);
    busCycle(1'b1, branchPkg::regInstr, curInstr, limit, unused, acked);
  endtask

  // read the head entry with flags last since that pops
  task automatic checkHead();
    logic [31:0] target;
    logic [31:0] link;
    logic [31:0] predRet;
    logic [31:0] flags;
    readReg(branchPkg::regTarget, target);
    readReg(branchPkg::regLink, link);
    readReg(branchPkg::regPredRet, predRet);
    readReg(branchPkg::regFlags, flags);
    if (qFlags.size() == 0) begin
      errorCount++;
      $display("result read back with no instruction outstanding in the model");
    end else begin
      checkEq("target", target, qTarget.pop_front());
      checkEq("link", link, qLink.pop_front());
      checkEq("predRet", predRet, qPredRet.pop_front());
      checkEq("flags", flags, qFlags.pop_front());
    end
  endtask

  task automatic runOne(input int kind);
    logic acked;
    makeInstr(kind);
    sendInstr(20, acked);
    if (!acked) begin
      errorCount++;
      $display("timeout: instruction write was never acknowledged");
    end else begin
      acceptModel();
      // entry is queued three cycles after the issue pulse
      repeat (2) @(negedge clk);
      checkHead();
    end
  endtask

  task automatic reportTest(input string name, input int chkBefore, input int errBefore);
    $display("test %s: %0d checks, %0d errors", name, checkCount - chkBefore,
             errorCount - errBefore);
  endtask

  initial begin
    int          chkBefore;
    int          errBefore;
    int          k;
    logic        acked;
    logic [31:0] data;
    lfsrState   = 16'd63168;
    checkCount  = 0;
    errorCount  = 0;
    rasPtrModel = 0;
    for (int i = 0; i < RAS_DEPTH; i++) begin
      rasModel[i] = '0;
    end
    rst     = 1'b1;
    wbCyc   = 1'b0;
    wbStb   = 1'b0;
    wbWe    = 1'b0;
    wbAdr   = '0;
    wbDatIn = '0;
    repeat (4) @(negedge clk);
    rst = 1'b0;

    // six conditions plus the compressed compare-with-zero forms
    chkBefore = checkCount;
    errBefore = errorCount;
    for (int i = 0; i < 48; i++) begin
      data = randBits(2);
      runOne((data[1:0] == 2'd0) ? kindCbranch : kindBranch);
    end
    reportTest("1 conditional branches", chkBefore, errBefore);

    chkBefore = checkCount;
    errBefore = errorCount;
    for (int i = 0; i < 48; i++) begin
      data = randBits(3);
      k    = int'(data[2:0]);
      if (k > 5) begin
        k = k - 6;
      end
      runOne(kindJal + k);
    end
    reportTest("2 jumps", chkBefore, errBefore);

    // more pushes than pops so the stack wraps
    chkBefore = checkCount;
    errBefore = errorCount;
    for (int i = 0; i < 64; i++) begin
      data = randBits(3);
      case (data[2:0])
        3'd0, 3'd1, 3'd2: runOne(kindCjal);
        3'd3, 3'd4, 3'd5: runOne(kindCjr);
        3'd6:             runOne(kindJal);
        default:          runOne(kindJalr);
      endcase
    end
    reportTest("3 return stack", chkBefore, errBefore);

    chkBefore = checkCount;
    errBefore = errorCount;
    for (int i = 0; i < 16; i++) begin
      runOne(kindOther);
    end
    readReg(branchPkg::regFlags, data);
    checkEq("flags valid on empty queue", data & 32'h1, 32'h0);
    reportTest("4 non-jumps", chkBefore, errBefore);

    // fill every credit and then one more
    chkBefore = checkCount;
    errBefore = errorCount;
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      data = randBits(3);
      makeInstr(int'(data[2:0]));
      sendInstr(20, acked);
      if (acked) begin
        acceptModel();
      end else begin
        errorCount++;
        $display("instruction write %0d not acknowledged although credit was free", i);
      end
    end
    makeInstr(kindJal);
    sendInstr(12, acked);
    checkEq("ack with queue full", {31'd0, acked}, 32'h0);
    if (acked) begin
      acceptModel();
    end
    // write-only registers read zero even with a full queue
    for (int a = 0; a < 4; a++) begin
      readReg(3'(a), data);
      checkEq("write-only register read", data, 32'h0);
    end
    repeat (2) @(negedge clk);
    checkHead();
    // pc, rs1, rs2 still hold the blocked instruction's operands
    busCycle(1'b1, branchPkg::regInstr, curInstr, 20, data, acked);
    if (acked) begin
      acceptModel();
    end else begin
      errorCount++;
      $display("timeout: blocked instruction write did not complete after a pop");
    end
    repeat (2) @(negedge clk);
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      checkHead();
    end
    readReg(branchPkg::regFlags, data);
    checkEq("flags valid after drain", data & 32'h1, 32'h0);
    reportTest("5 back-pressure", chkBefore, errBefore);

    $display("total: %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
